//--- memStage.f
+incdir+design
design/memStagePkg.sv
design/memAccessGen.sv
design/dataRam.sv
design/loadAlign.sv
design/memStage.sv
verif/memStage_chk.sv
verif/memStage_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the memStage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module memStage_tb \
	-f memStage.f -o memStageSim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/memStageSim > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi

cat sim.log
if grep -q "^sim passed$" sim.log; then
	exit 0
fi
exit 1

//--- verif/memStage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "memStage_config.svh"

module memStage_tb import memStagePkg::*; ();

	// reset, directed tests, 64 fills, 200 random requests and the drains
	localparam int STIM_CYCLES = 360;
	localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 50;

	typedef struct packed {
		logic    err;
		logic    load;
		regIdx_t rd;
		word_t   data;
		word_t   pc;
		word_t   vaddr;
	} expect_t;

	logic        clk = 1'b0;
	logic        rstN;
	logic        reqValid;
	logic        reqStore;
	accessSize_t reqSize;
	logic        reqSignExt;
	word_t       reqPc;
	word_t       reqVaddr;
	word_t       reqWdata;
	regIdx_t     reqRd;
	word_t       debugWbPc;
	byteEn_t     debugWbRfWen;
	regIdx_t     debugWbRfWnum;
	word_t       debugWbRfWdata;
	logic        excValid;
	word_t       badVaddr;

	expect_t     expQ [$];
	word_t       shadow [2**`RAM_AW];
	logic [2:0]  validPipe = 3'b000;
	int          errors = 0;
	int          cycles = 0;
	int          testErrBase = 0;
	int          pcCount = 0;

	memStage memStage_inst (.*);

	always #5 clk = ~clk;

	// expected trace or exception for one request and the shadow memory update
	function automatic expect_t refModel(input logic store, accessSize_t size, logic signExt,
			word_t pc, word_t vaddr, word_t wdata, regIdx_t rd);
		expect_t    e;
		word_t      paddr;
		logic [1:0] off;
		ramIdx_t    idx;
		word_t      w;
		logic [7:0] b;
		logic [15:0] h;
		paddr = vaddr - `KSEG1_BASE;
		off = paddr[1:0];
		idx = paddr[`RAM_AW+1:2];
		e = '0;
		e.pc = pc;
		e.vaddr = vaddr;
		e.rd = rd;
		if (size == `SIZE_HALF)
			e.err = off[0];
		else if (size == `SIZE_WORD)
			e.err = (off != 2'b00);
		e.load = !store && !e.err;
		if (store && !e.err) begin
			case (size)
				`SIZE_BYTE: shadow[idx][8*off +: 8] = wdata[7:0];
				`SIZE_HALF: shadow[idx][16*off[1] +: 16] = wdata[15:0];
				default:    shadow[idx] = wdata;
			endcase
		end
		w = shadow[idx];
		b = w[8*off +: 8];
		h = w[16*off[1] +: 16];
		case (size)
			`SIZE_BYTE: e.data = signExt ? {{24{b[7]}}, b} : {24'h0, b};
			`SIZE_HALF: e.data = signExt ? {{16{h[15]}}, h} : {16'h0, h};
			default:    e.data = w;
		endcase
		return e;
	endfunction

	function automatic word_t va(input int wordIdx, input int off);
		return `KSEG1_BASE + word_t'(wordIdx * 4 + off);
	endfunction

	task automatic checkValue(input string name, input word_t expVal, input word_t actVal);
		if (expVal !== actVal) begin
			$display("error at %0t: %s expected %h got %h", $time, name, expVal, actVal);
			errors++;
		end
	endtask

	task automatic issue(input logic store, accessSize_t size, logic signExt,
			word_t vaddr, word_t wdata, regIdx_t rd);
		word_t pc;
		pc = 32'hBFC0_0000 + word_t'(pcCount * 4);
		pcCount++;
		@(posedge clk);
		expQ.push_back(refModel(store, size, signExt, pc, vaddr, wdata, rd));
		reqValid <= 1'b1;
		reqStore <= store;
		reqSize <= size;
		reqSignExt <= signExt;
		reqPc <= pc;
		reqVaddr <= vaddr;
		reqWdata <= wdata;
		reqRd <= rd;
	endtask

	task automatic idle();
		@(posedge clk);
		reqValid <= 1'b0;
	endtask

	task automatic finishTest(input string name);
		idle();
		while (expQ.size() != 0) @(posedge clk);
		if (errors == testErrBase)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d mismatches", name, errors - testErrBase);
		testErrBase = errors;
	endtask

	// outputs of the slot accepted three edges back
	always @(posedge clk) begin
		expect_t e;
		if (validPipe[2]) begin
			if (expQ.size() == 0) begin
				$display("compare: output slot arrived with no expected entry");
				errors++;
			end else begin
				e = expQ.pop_front();
				checkValue("debugWbPc", e.pc, debugWbPc);
				checkValue("excValid", word_t'(e.err), word_t'(excValid));
				checkValue("debugWbRfWen", e.load ? 32'hF : 32'h0, word_t'(debugWbRfWen));
				if (e.err)
					checkValue("badVaddr", e.vaddr, badVaddr);
				if (e.load) begin
					checkValue("debugWbRfWnum", word_t'(e.rd), word_t'(debugWbRfWnum));
					checkValue("debugWbRfWdata", e.data, debugWbRfWdata);
				end
			end
		end else if (rstN) begin
			checkValue("debugWbRfWen", 32'h0, word_t'(debugWbRfWen));
			checkValue("excValid", 32'h0, word_t'(excValid));
		end
		validPipe <= {validPipe[1:0], reqValid};
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		word_t r;
		accessSize_t sz;
		rstN = 1'b0;
		reqValid = 1'b0;
		reqStore = 1'b0;
		reqSize = `SIZE_WORD;
		reqSignExt = 1'b0;
		reqPc = '0;
		reqVaddr = '0;
		reqWdata = '0;
		reqRd = '0;
		void'($urandom(8));
		repeat (10) @(posedge clk);
		rstN <= 1'b1;

		repeat (5) idle();
		finishTest("idle after reset");

		issue(1'b1, `SIZE_WORD, 1'b0, va(1, 0), 32'hDEAD_BEEF, 5'd0);
		issue(1'b0, `SIZE_WORD, 1'b0, va(1, 0), 32'h0, 5'd7);
		finishTest("word store then load");

		issue(1'b1, `SIZE_WORD, 1'b0, va(2, 0), 32'h0, 5'd0);
		issue(1'b1, `SIZE_WORD, 1'b0, va(3, 0), 32'hFFFF_FFFF, 5'd0);
		issue(1'b1, `SIZE_WORD, 1'b0, va(4, 0), 32'h1122_3344, 5'd0);
		for (int o = 0; o < 4; o++)
			issue(1'b1, `SIZE_BYTE, 1'b0, va(2, o), 32'h10 + word_t'(o), 5'd0);
		issue(1'b1, `SIZE_HALF, 1'b0, va(3, 0), 32'h0000_A1B2, 5'd0);
		issue(1'b1, `SIZE_HALF, 1'b0, va(3, 2), 32'h0000_C3D4, 5'd0);
		issue(1'b1, `SIZE_BYTE, 1'b0, va(4, 1), 32'h0000_00AA, 5'd0);
		issue(1'b1, `SIZE_HALF, 1'b0, va(4, 2), 32'h0000_5566, 5'd0);
		for (int w = 2; w < 5; w++)
			issue(1'b0, `SIZE_WORD, 1'b0, va(w, 0), 32'h0, regIdx_t'(w));
		finishTest("byte and half merge");

		issue(1'b1, `SIZE_WORD, 1'b0, va(5, 0), 32'h80F0_7F01, 5'd0);
		for (int o = 0; o < 4; o++) begin
			issue(1'b0, `SIZE_BYTE, 1'b1, va(5, o), 32'h0, regIdx_t'(o + 1));
			issue(1'b0, `SIZE_BYTE, 1'b0, va(5, o), 32'h0, regIdx_t'(o + 9));
		end
		for (int o = 0; o < 4; o += 2) begin
			issue(1'b0, `SIZE_HALF, 1'b1, va(5, o), 32'h0, 5'd20);
			issue(1'b0, `SIZE_HALF, 1'b0, va(5, o), 32'h0, 5'd21);
		end
		finishTest("load extension");

		issue(1'b1, `SIZE_WORD, 1'b0, va(6, 0), 32'h0BAD_F00D, 5'd0);
		issue(1'b1, `SIZE_HALF, 1'b0, va(6, 1), 32'hFFFF_FFFF, 5'd0);
		issue(1'b1, `SIZE_WORD, 1'b0, va(6, 2), 32'hFFFF_FFFF, 5'd0);
		issue(1'b0, `SIZE_WORD, 1'b0, va(1, 3), 32'h0, 5'd3);
		issue(1'b0, `SIZE_HALF, 1'b1, va(1, 1), 32'h0, 5'd4);
		issue(1'b0, `SIZE_WORD, 1'b0, va(6, 0), 32'h0, 5'd5);
		finishTest("misaligned access");

		for (int w = 64; w < 128; w++)
			issue(1'b1, `SIZE_WORD, 1'b0, va(w, 0), $urandom, 5'd0);
		for (int n = 0; n < 200; n++) begin
			r = $urandom;
			sz = (r[2:1] == 2'd3) ? `SIZE_WORD : r[2:1];
			issue(r[0], sz, r[3], va(64 + int'(r[9:4]), int'(r[11:10])), $urandom,
				regIdx_t'(r[16:12]));
		end
		finishTest("random mixed");

		$display("tests done: %0d mismatches in %0d cycles", errors, cycles);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/memStage_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "memStage_config.svh"

module memStage_chk import memStagePkg::*; (
	input wire     clk,
	input wire     rstN,
	input wire     reqValid,
	input wire     reqStore,
	input word_t   reqPc,
	input word_t   debugWbPc,
	input byteEn_t debugWbRfWen,
	input wire     excValid
);

	// a set trace enable has all lanes and belongs to a load
	wenAllOrNone: assert property (@(posedge clk) disable iff (!rstN)
		(debugWbRfWen != 4'b0000) |->
			((debugWbRfWen == 4'b1111) && $past(reqValid, 3) && !$past(reqStore, 3)))
		else $error("debugWbRfWen partially set or set without a load");

	wenNotWithExc: assert property (@(posedge clk) disable iff (!rstN)
		excValid |-> ((debugWbRfWen == 4'b0000) && $past(reqValid, 3)))
		else $error("exception pulse with a register write or without a request");

	// fixed latency of three edges
	slotRetires: assert property (@(posedge clk) disable iff (!rstN)
		$past(reqValid, 3) |-> (excValid || debugWbPc == $past(reqPc, 3)))
		else $error("accepted request gave no trace update");

endmodule

bind memStage memStage_chk memStageChkInst (.*);

`default_nettype wire

//--- design/memStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "memStage_config.svh"

module memStage import memStagePkg::*; (
	input  wire         clk,
	input  wire         rstN,
	input  wire         reqValid,
	input  wire         reqStore,
	input  accessSize_t reqSize,
	input  wire         reqSignExt,
	input  word_t       reqPc,
	input  word_t       reqVaddr,
	input  word_t       reqWdata,
	input  regIdx_t     reqRd,
	output word_t       debugWbPc,
	output byteEn_t     debugWbRfWen,
	output regIdx_t     debugWbRfWnum,
	output word_t       debugWbRfWdata,
	output logic        excValid,
	output word_t       badVaddr
);

	logic        ramEn;
	byteEn_t     ramWe;
	ramIdx_t     ramIdx;
	word_t       ramWdata;
	word_t       ramRdata;
	logic        s1Valid;
	logic        s1Load;
	accessSize_t s1Size;
	logic        s1SignExt;
	byteOff_t    s1Off;
	word_t       s1Pc;
	regIdx_t     s1Rd;
	logic        s1AddrErr;
	word_t       s1Vaddr;

	memAccessGen memAccessGenInst (
		.clk(clk), .rstN(rstN),
		.reqValid(reqValid), .reqStore(reqStore), .reqSize(reqSize),
		.reqSignExt(reqSignExt), .reqPc(reqPc), .reqVaddr(reqVaddr),
		.reqWdata(reqWdata), .reqRd(reqRd),
		.ramEn(ramEn), .ramWe(ramWe), .ramIdx(ramIdx), .ramWdata(ramWdata),
		.s1Valid(s1Valid), .s1Load(s1Load), .s1Size(s1Size), .s1SignExt(s1SignExt),
		.s1Off(s1Off), .s1Pc(s1Pc), .s1Rd(s1Rd), .s1AddrErr(s1AddrErr), .s1Vaddr(s1Vaddr)
	);

	dataRam dataRamInst (
		.clk(clk), .ramEn(ramEn), .ramWe(ramWe), .ramIdx(ramIdx),
		.ramWdata(ramWdata), .ramRdata(ramRdata)
	);

	loadAlign loadAlignInst (
		.clk(clk), .rstN(rstN),
		.s1Valid(s1Valid), .s1Load(s1Load), .s1Size(s1Size), .s1SignExt(s1SignExt),
		.s1Off(s1Off), .s1Pc(s1Pc), .s1Rd(s1Rd), .s1AddrErr(s1AddrErr), .s1Vaddr(s1Vaddr),
		.ramRdata(ramRdata),
		.debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen), .debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata), .excValid(excValid), .badVaddr(badVaddr)
	);

endmodule

`default_nettype wire

//--- design/loadAlign.sv
`timescale 1ns/1ps
`default_nettype none

`include "memStage_config.svh"

module loadAlign import memStagePkg::*; (
	input  wire         clk,
	input  wire         rstN,
	input  wire         s1Valid,
	input  wire         s1Load,
	input  accessSize_t s1Size,
	input  wire         s1SignExt,
	input  byteOff_t    s1Off,
	input  word_t       s1Pc,
	input  regIdx_t     s1Rd,
	input  wire         s1AddrErr,
	input  word_t       s1Vaddr,
	input  word_t       ramRdata,
	output word_t       debugWbPc,
	output byteEn_t     debugWbRfWen,
	output regIdx_t     debugWbRfWnum,
	output word_t       debugWbRfWdata,
	output logic        excValid,
	output word_t       badVaddr
);

	logic        s2Valid;
	logic        s2Load;
	accessSize_t s2Size;
	logic        s2SignExt;
	byteOff_t    s2Off;
	word_t       s2Pc;
	regIdx_t     s2Rd;
	logic        s2AddrErr;
	word_t       s2Vaddr;
	logic [7:0]  loadByte;
	logic [15:0] loadHalf;
	word_t       loadData;
	logic        goodLoad;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			s2Valid <= 1'b0;
			debugWbRfWen <= '0;
			excValid <= 1'b0;
		end else begin
			s2Valid <= s1Valid;
			debugWbRfWen <= goodLoad ? '1 : '0;
			excValid <= s2Valid & s2AddrErr;
		end
	end

	// sideband waits one cycle for the memory word
	always_ff @(posedge clk) begin
		if (s1Valid) begin
			s2Load <= s1Load;
			s2Size <= s1Size;
			s2SignExt <= s1SignExt;
			s2Off <= s1Off;
			s2Pc <= s1Pc;
			s2Rd <= s1Rd;
			s2AddrErr <= s1AddrErr;
			s2Vaddr <= s1Vaddr;
		end
	end

	assign goodLoad = s2Valid & s2Load & ~s2AddrErr;

	// same job as the load bridge in the full core
	always_comb begin
		loadByte = ramRdata[{s2Off, 3'b000} +: 8];
		loadHalf = s2Off[1] ? ramRdata[31:16] : ramRdata[15:0];
		case (s2Size)
			`SIZE_BYTE: loadData = {{(`WORD_W-8){s2SignExt & loadByte[7]}}, loadByte};
			`SIZE_HALF: loadData = {{(`WORD_W-16){s2SignExt & loadHalf[15]}}, loadHalf};
			default:    loadData = ramRdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (s2Valid) begin
			debugWbPc <= s2Pc;
		end
		if (goodLoad) begin
			debugWbRfWnum <= s2Rd;
			debugWbRfWdata <= loadData;
		end
		if (s2Valid & s2AddrErr) begin
			badVaddr <= s2Vaddr;
		end
	end

endmodule

`default_nettype wire

//--- design/dataRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "memStage_config.svh"

module dataRam import memStagePkg::*; (
	input  wire     clk,
	input  wire     ramEn,
	input  byteEn_t ramWe,
	input  ramIdx_t ramIdx,
	input  word_t   ramWdata,
	output word_t   ramRdata
);

	word_t mem [2**`RAM_AW];

	// stands in for the dcache, fixed one-cycle access
	always_ff @(posedge clk) begin
		if (ramEn) begin
			for (int i = 0; i < 4; i++) begin
				if (ramWe[i]) begin
					mem[ramIdx][8*i +: 8] <= ramWdata[8*i +: 8];
				end
			end
			// old word on a same-edge write
			ramRdata <= mem[ramIdx];
		end
	end

endmodule

`default_nettype wire

//--- design/memAccessGen.sv
`timescale 1ns/1ps
`default_nettype none

`include "memStage_config.svh"

module memAccessGen import memStagePkg::*; (
	input  wire         clk,
	input  wire         rstN,
	input  wire         reqValid,
	input  wire         reqStore,
	input  accessSize_t reqSize,
	input  wire         reqSignExt,
	input  word_t       reqPc,
	input  word_t       reqVaddr,
	input  word_t       reqWdata,
	input  regIdx_t     reqRd,
	output logic        ramEn,
	output byteEn_t     ramWe,
	output ramIdx_t     ramIdx,
	output word_t       ramWdata,
	output logic        s1Valid,
	output logic        s1Load,
	output accessSize_t s1Size,
	output logic        s1SignExt,
	output byteOff_t    s1Off,
	output word_t       s1Pc,
	output regIdx_t     s1Rd,
	output logic        s1AddrErr,
	output word_t       s1Vaddr
);

	word_t    paddr;
	byteOff_t off;
	logic     misaligned;
	byteEn_t  strobe;
	word_t    laneData;

	// kseg1 translation
	assign paddr = reqVaddr - `KSEG1_BASE;
	assign off = paddr[1:0];

	always_comb begin
		case (reqSize)
			`SIZE_BYTE: begin
				misaligned = 1'b0;
				strobe = byteEn_t'(4'b0001 << off);
				laneData = {4{reqWdata[7:0]}};
			end
			`SIZE_HALF: begin
				misaligned = off[0];
				strobe = off[1] ? 4'b1100 : 4'b0011;
				laneData = {2{reqWdata[15:0]}};
			end
			default: begin
				misaligned = |off;
				strobe = 4'b1111;
				laneData = reqWdata;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ramEn <= 1'b0;
			ramWe <= '0;
			s1Valid <= 1'b0;
		end else begin
			// a bad address never reaches the memory
			ramEn <= reqValid & ~misaligned;
			ramWe <= (reqValid & reqStore & ~misaligned) ? strobe : '0;
			s1Valid <= reqValid;
		end
	end

	always_ff @(posedge clk) begin
		if (reqValid) begin
			ramIdx <= paddr[`RAM_AW+1:2];
			ramWdata <= laneData;
			s1Load <= ~reqStore;
			s1Size <= reqSize;
			s1SignExt <= reqSignExt;
			s1Off <= off;
			s1Pc <= reqPc;
			s1Rd <= reqRd;
			s1AddrErr <= misaligned;
			s1Vaddr <= reqVaddr;
		end
	end

endmodule

`default_nettype wire

//--- design/memStagePkg.sv
`default_nettype none

`include "memStage_config.svh"

package memStagePkg;

	// data word or address
	typedef logic [`WORD_W-1:0] word_t;

	// per-byte write strobe, also the trace write enable
	typedef logic [3:0] byteEn_t;

	// destination register number
	typedef logic [`REG_AW-1:0] regIdx_t;

	// word index into the data memory
	typedef logic [`RAM_AW-1:0] ramIdx_t;

	// byte position inside a word
	typedef logic [1:0] byteOff_t;

	// holds one of the SIZE_* codes
	typedef logic [1:0] accessSize_t;

endpackage

`default_nettype wire

//--- design/memStage_config.svh
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// datapath and address width
`define WORD_W 32

// data memory word-index width, 256 words
`define RAM_AW 8

// register-number width
`define REG_AW 5

// kseg1 is unmapped, fixed offset to physical
`define KSEG1_BASE 32'hA000_0000

// access-size codes
`define SIZE_BYTE 2'd0
`define SIZE_HALF 2'd1
`define SIZE_WORD 2'd2

`endif
